//--- tb.f
+incdir+design
design/ex_pkg.sv
design/pipe_stage_reg.sv
design/alu.sv
design/ex_stage.sv
design/mem_stage.sv
design/ex_mem_top.sv
tests/ex_mem_assert.sv
tests/tb_ex_mem.sv

//--- Makefile
# Verilator simulation of the execute/memory pipeline

SIM := obj_dir/Vtb_ex_mem

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build products and the log"

$(SIM): tb.f $(wildcard design/*.sv design/*.svh tests/*.sv)
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module tb_ex_mem -f tb.f -Mdir obj_dir

test: $(SIM)
	./$(SIM) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ]; then echo "Simulation aborted"; exit 1; fi
	@if grep -q "TESTBENCH FAILED" sim.log; then echo "Failure found in sim.log"; exit 1; fi
	@echo "No failure found in sim.log"

clean:
	rm -rf obj_dir sim.log

//--- tests/tb_ex_mem.sv
`include "ex_defines.svh"

module tb_ex_mem;

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] SEED = 32'h271f_5a96;
    localparam int N_ALU = 200;
    localparam int N_LAT = 100;
    localparam int N_MEM = 150;
    localparam int N_BP  = 300;
    // Up to 3 idle cycles per instruction plus stalls, with a wide margin
    localparam int TIMEOUT_NS = ((N_ALU + N_LAT + N_MEM + N_BP) * 24 + 200) * 8;
    localparam ex_pkg::fwd_t FWD_EMPTY = '0;

    typedef struct packed {
        ex_pkg::mem_to_wb_t wb;
        ex_pkg::fwd_t       ex_fwd;
        ex_pkg::fwd_t       mem_fwd;
        logic [31:0]        acc_cycle;
    } exp_t;

    logic                  clk = 1'b0;
    logic                  resetn;
    logic                  id_to_ex_valid;
    ex_pkg::id_to_ex_t     id_to_ex;
    logic                  id_allowin;
    logic                  wb_allowin;
    logic                  mem_to_wb_valid;
    ex_pkg::mem_to_wb_t    mem_to_wb;
    ex_pkg::fwd_t          ex_fwd;
    ex_pkg::fwd_t          mem_fwd;
    logic                  data_sram_en;
    logic [3:0]            data_sram_we;
    logic [`EX_DATA_W-1:0] data_sram_addr;
    logic [`EX_DATA_W-1:0] data_sram_wdata;
    logic [`EX_DATA_W-1:0] data_sram_rdata;

    logic [31:0] stim_lfsr;
    logic [31:0] stall_lfsr;
    logic        stall_on = 1'b0;
    logic        check_latency = 1'b1;
    int          chk_errors;
    int          mon_errors;
    int          fwd_errors;
    int          fwd_cycles;
    int          checked_outputs;
    int          stores_seen;
    int          sram_writes;
    int          cycle_cnt;
    int          seq;
    logic [31:0] sram [64];
    logic [31:0] model_mem [64];
    exp_t        exp_q [$];
    logic        ex_v;
    logic        mem_v;
    exp_t        ex_rec;
    exp_t        mem_rec;

    always #4 clk = ~clk;

    ex_mem_top u_ex_mem_top (
        .clk             (clk),
        .resetn          (resetn),
        .id_to_ex_valid  (id_to_ex_valid),
        .id_to_ex        (id_to_ex),
        .id_allowin      (id_allowin),
        .wb_allowin      (wb_allowin),
        .mem_to_wb_valid (mem_to_wb_valid),
        .mem_to_wb       (mem_to_wb),
        .ex_fwd          (ex_fwd),
        .mem_fwd         (mem_fwd),
        .data_sram_en    (data_sram_en),
        .data_sram_we    (data_sram_we),
        .data_sram_addr  (data_sram_addr),
        .data_sram_wdata (data_sram_wdata),
        .data_sram_rdata (data_sram_rdata)
    );

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] lfsr_take(inout logic [31:0] state, input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], state[0]};
            state = state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
        end
        return r;
    endfunction

    function automatic logic [31:0] fill_word(input int i);
        return 32'h5ee0_0000 ^ (32'(i) * 32'h0001_0409) ^ (32'(i) << 26);
    endfunction

    function automatic logic [31:0] alu_ref(input int idx, input logic [31:0] a,
                                            input logic [31:0] b);
        case (idx)
            0:       return a + b;
            1:       return a - b;
            2:       return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3:       return (a < b) ? 32'd1 : 32'd0;
            4:       return a & b;
            5:       return ~(a | b);
            6:       return a | b;
            7:       return a ^ b;
            8:       return a << b[4:0];
            9:       return a >> b[4:0];
            10:      return $unsigned($signed(a) >>> b[4:0]);
            11:      return b;
            default: return 32'd0;
        endcase
    endfunction

    // kind 0 is ALU only, 1 loads and stores, 2 a mix of all three
    function automatic ex_pkg::id_to_ex_t make_instr(input int kind);
        ex_pkg::id_to_ex_t ins;
        logic [31:0]       r;
        int                cls;
        r = lfsr_take(stim_lfsr, 2);
        case (kind)
            0:       cls = 0;
            1:       cls = r[0] ? 1 : 2;
            default: cls = r[1] ? 0 : (r[0] ? 1 : 2);
        endcase
        ins.pc = 32'h1c00_0000 + 32'(seq) * 4;
        seq = seq + 1;
        r = lfsr_take(stim_lfsr, 5);
        ins.rf_waddr = r[4:0];
        ins.rkd_value = lfsr_take(stim_lfsr, 32);
        ins.mem_we = (cls == 2);
        ins.res_from_mem = (cls == 1);
        if (cls == 0) begin
            r = lfsr_take(stim_lfsr, 4);
            ins.alu_op = `EX_ALU_OPS'(1) << (int'(r[3:0]) % `EX_ALU_OPS);
            ins.alu_src1 = lfsr_take(stim_lfsr, 32);
            ins.alu_src2 = lfsr_take(stim_lfsr, 32);
            r = lfsr_take(stim_lfsr, 1);
            ins.rf_we = r[0];
        end else begin
            // Word address from an add, kept inside the 64-word SRAM
            ins.alu_op = `EX_ALU_OPS'(1);
            ins.alu_src1 = lfsr_take(stim_lfsr, 32) & 32'h7c;
            ins.alu_src2 = lfsr_take(stim_lfsr, 32) & 32'h7c;
            ins.rf_we = (cls == 1);
        end
        return ins;
    endfunction

    function automatic exp_t model_exec(input ex_pkg::id_to_ex_t ins, input int cycle);
        exp_t        e;
        int          idx;
        logic [31:0] res;
        logic [31:0] fin;
        idx = -1;
        for (int i = 0; i < `EX_ALU_OPS; i++) begin
            if (ins.alu_op[i]) idx = i;
        end
        res = alu_ref(idx, ins.alu_src1, ins.alu_src2);
        fin = res;
        if (ins.mem_we) begin
            model_mem[res[7:2]] = ins.rkd_value;
            stores_seen = stores_seen + 1;
        end
        if (ins.res_from_mem) begin
            fin = model_mem[res[7:2]];
        end
        e.wb.rf_we = ins.rf_we;
        e.wb.rf_waddr = ins.rf_waddr;
        e.wb.pc = ins.pc;
        e.wb.final_result = fin;
        e.ex_fwd.is_load = ins.res_from_mem;
        e.ex_fwd.rf_we = ins.rf_we;
        e.ex_fwd.rf_waddr = ins.rf_waddr;
        e.ex_fwd.value = res;
        e.mem_fwd = e.ex_fwd;
        e.mem_fwd.value = fin;
        e.acc_cycle = 32'(cycle);
        return e;
    endfunction

    task automatic show_fail(input string msg);
        $display("FAIL %0t: %s", $time, msg);
    endtask

    task automatic issue(input ex_pkg::id_to_ex_t ins);
        @(negedge clk);
        id_to_ex_valid = 1'b1;
        id_to_ex = ins;
        @(posedge clk);
        while (!id_allowin) begin
            @(posedge clk);
        end
    endtask

    task automatic idle(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            id_to_ex_valid = 1'b0;
        end
    endtask

    task automatic run_traffic(input int num, input string name, input int kind,
                               input int count, input logic gaps, input logic stalls);
        int          errs_before;
        logic [31:0] r;
        errs_before = chk_errors + mon_errors;
        check_latency = !stalls;
        stall_on = stalls;
        for (int i = 0; i < count; i++) begin
            issue(make_instr(kind));
            if (gaps) begin
                r = lfsr_take(stim_lfsr, 2);
                idle(int'(r[1:0]));
            end
        end
        idle(1);
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        stall_on = 1'b0;
        // Each store must reach the SRAM exactly once
        assert (sram_writes == stores_seen) else begin
            show_fail($sformatf("%0d SRAM writes for %0d stores", sram_writes, stores_seen));
            chk_errors++;
        end
        $display("Test %0d %s: %0d instructions, %0d errors", num, name, count,
                 chk_errors + mon_errors - errs_before);
    endtask

    //////////////////////////////
    // Data SRAM, one-cycle read
    //////////////////////////////
    initial begin
        logic [31:0] read_word;
        for (int i = 0; i < 64; i++) begin
            sram[i] = fill_word(i);
        end
        read_word = '0;
        data_sram_rdata = '0;
        forever begin
            @(posedge clk);
            if (data_sram_en) begin
                read_word = sram[data_sram_addr[7:2]];
                if (data_sram_we == 4'hf) begin
                    sram[data_sram_addr[7:2]] = data_sram_wdata;
                    sram_writes++;
                end
            end
            // Held while the enable stays low
            @(negedge clk);
            data_sram_rdata = read_word;
        end
    end

    // Write-back back-pressure on its own LFSR stream
    initial begin
        logic [31:0] r;
        stall_lfsr = ~SEED;
        wb_allowin = 1'b1;
        forever begin
            @(negedge clk);
            r = lfsr_take(stall_lfsr, 2);
            wb_allowin = stall_on ? (r[1:0] != 2'b00) : 1'b1;
        end
    end

    //////////////////////////////
    // Reference pipeline
    //////////////////////////////
    initial begin
        logic m_mem_allowin;
        logic m_id_allowin;
        exp_t head;
        for (int i = 0; i < 64; i++) begin
            model_mem[i] = fill_word(i);
        end
        ex_v = 1'b0;
        mem_v = 1'b0;
        forever begin
            @(posedge clk);
            cycle_cnt++;
            if (!resetn) begin
                ex_v = 1'b0;
                mem_v = 1'b0;
                exp_q.delete();
            end else begin
                m_mem_allowin = !mem_v || wb_allowin;
                m_id_allowin = !ex_v || m_mem_allowin;
                assert (id_allowin == m_id_allowin && mem_to_wb_valid == mem_v) else begin
                    show_fail($sformatf("id_allowin %0b valid %0b, expected %0b %0b",
                              id_allowin, mem_to_wb_valid, m_id_allowin, mem_v));
                    mon_errors++;
                end
                fwd_cycles++;
                assert (ex_fwd == (ex_v ? ex_rec.ex_fwd : FWD_EMPTY)
                        && mem_fwd == (mem_v ? mem_rec.mem_fwd : FWD_EMPTY)) else begin
                    show_fail($sformatf("ex_fwd %h mem_fwd %h", ex_fwd, mem_fwd));
                    fwd_errors++;
                end
                if (mem_v && wb_allowin) begin
                    head = exp_q.pop_front();
                    checked_outputs++;
                    assert (mem_to_wb == head.wb) else begin
                        show_fail($sformatf("pc %h result %h, expected pc %h result %h",
                                  mem_to_wb.pc, mem_to_wb.final_result,
                                  head.wb.pc, head.wb.final_result));
                        mon_errors++;
                    end
                    if (check_latency) begin
                        assert (32'(cycle_cnt) == head.acc_cycle + 2) else begin
                            show_fail($sformatf("pc %h left after %0d cycles", head.wb.pc,
                                      32'(cycle_cnt) - head.acc_cycle));
                            mon_errors++;
                        end
                    end
                end
                // Mem advances before ex so the ex record moves forward first
                if (m_mem_allowin) begin
                    mem_v = ex_v;
                    mem_rec = ex_rec;
                end
                if (m_id_allowin) begin
                    ex_v = id_to_ex_valid;
                    if (id_to_ex_valid) begin
                        ex_rec = model_exec(id_to_ex, cycle_cnt);
                        exp_q.push_back(ex_rec);
                    end
                end
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired after %0d ns, the pipeline stopped making progress",
                 TIMEOUT_NS);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        int total;
        resetn = 1'b0;
        id_to_ex_valid = 1'b0;
        id_to_ex = '0;
        stim_lfsr = SEED;
        repeat (3) @(negedge clk);
        resetn = 1'b1;
        @(posedge clk);
        assert (!mem_to_wb_valid && !data_sram_en && !ex_fwd.rf_we && !mem_fwd.rf_we
                && !ex_fwd.is_load && !mem_fwd.is_load && id_allowin) else begin
            show_fail("outputs not idle after reset");
            chk_errors++;
        end
        $display("Test 1 reset: %0d errors", chk_errors);
        run_traffic(2, "alu", 0, N_ALU, 1'b0, 1'b0);
        run_traffic(3, "latency", 2, N_LAT, 1'b1, 1'b0);
        run_traffic(4, "load/store", 1, N_MEM, 1'b1, 1'b0);
        run_traffic(5, "back-pressure", 2, N_BP, 1'b1, 1'b1);
        $display("Test 6 forwarding: %0d cycles, %0d errors", fwd_cycles, fwd_errors);
        total = chk_errors + mon_errors + fwd_errors + u_ex_mem_top.u_ex_mem_assert.failures;
        $display("Summary: 6 tests, %0d outputs checked, %0d errors", checked_outputs, total);
        if (total == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- tests/ex_mem_assert.sv
`include "ex_defines.svh"

module ex_mem_assert (
    input logic               clk,
    input logic               resetn,
    input logic               wb_allowin,
    input logic               mem_to_wb_valid,
    input ex_pkg::mem_to_wb_t mem_to_wb,
    input logic               data_sram_en,
    input logic [3:0]         data_sram_we
);

    timeunit 1ns;
    timeprecision 1ps;

    int en_fails;
    int hold_fails;
    int we_fails;
    int failures;

    assign failures = en_fails + hold_fails + we_fails;

    // Stage valid bits clear on the reset edge
    a_en_reset: assert property (@(posedge clk) !resetn |=> !data_sram_en)
        else begin
            $error("data_sram_en high after a reset edge");
            en_fails++;
        end

    // A stalled write-back request keeps its payload
    a_wb_hold: assert property (@(posedge clk) disable iff (!resetn)
        (mem_to_wb_valid && !wb_allowin) |=> (mem_to_wb_valid && $stable(mem_to_wb)))
        else begin
            $error("mem_to_wb changed while write-back was stalled");
            hold_fails++;
        end

    // A store strobe comes with the enable and lands the store in mem
    a_we_en: assert property (@(posedge clk) disable iff (!resetn)
        (|data_sram_we) |-> data_sram_en ##1 mem_to_wb_valid)
        else begin
            $error("data_sram_we set without data_sram_en or a transfer to mem");
            we_fails++;
        end

endmodule

bind ex_mem_top ex_mem_assert u_ex_mem_assert (.*);

//--- design/ex_mem_top.sv
`include "ex_defines.svh"

module ex_mem_top (
    input  logic                  clk,
    input  logic                  resetn,
    // Decode side
    input  logic                  id_to_ex_valid,
    input  ex_pkg::id_to_ex_t     id_to_ex,
    output logic                  id_allowin,
    // Write-back side
    input  logic                  wb_allowin,
    output logic                  mem_to_wb_valid,
    output ex_pkg::mem_to_wb_t    mem_to_wb,
    // Bypass toward decode
    output ex_pkg::fwd_t          ex_fwd,
    output ex_pkg::fwd_t          mem_fwd,
    // Data SRAM
    output logic                  data_sram_en,
    output logic [3:0]            data_sram_we,
    output logic [`EX_DATA_W-1:0] data_sram_addr,
    output logic [`EX_DATA_W-1:0] data_sram_wdata,
    input  logic [`EX_DATA_W-1:0] data_sram_rdata
);

    logic               mem_allowin;
    logic               ex_to_mem_valid;
    ex_pkg::ex_to_mem_t ex_to_mem;

    ex_stage u_ex_stage (
        .clk             (clk),
        .resetn          (resetn),
        .id_to_ex_valid  (id_to_ex_valid),
        .id_to_ex        (id_to_ex),
        .id_allowin      (id_allowin),
        .mem_allowin     (mem_allowin),
        .ex_to_mem_valid (ex_to_mem_valid),
        .ex_to_mem       (ex_to_mem),
        .ex_fwd          (ex_fwd),
        .data_sram_en    (data_sram_en),
        .data_sram_we    (data_sram_we),
        .data_sram_addr  (data_sram_addr),
        .data_sram_wdata (data_sram_wdata)
    );

    mem_stage u_mem_stage (
        .clk             (clk),
        .resetn          (resetn),
        .ex_to_mem_valid (ex_to_mem_valid),
        .ex_to_mem       (ex_to_mem),
        .mem_allowin     (mem_allowin),
        .data_sram_rdata (data_sram_rdata),
        .wb_allowin      (wb_allowin),
        .mem_to_wb_valid (mem_to_wb_valid),
        .mem_to_wb       (mem_to_wb),
        .mem_fwd         (mem_fwd)
    );

endmodule

//--- design/mem_stage.sv
`include "ex_defines.svh"

module mem_stage (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  ex_to_mem_valid,
    input  ex_pkg::ex_to_mem_t    ex_to_mem,
    output logic                  mem_allowin,
    input  logic [`EX_DATA_W-1:0] data_sram_rdata,
    input  logic                  wb_allowin,
    output logic                  mem_to_wb_valid,
    output ex_pkg::mem_to_wb_t    mem_to_wb,
    output ex_pkg::fwd_t          mem_fwd
);

    ex_pkg::ex_to_mem_t    mem_data;
    logic [`EX_DATA_W-1:0] final_result;

    pipe_stage_reg #(.payload_t(ex_pkg::ex_to_mem_t)) u_mem_reg (
        .clk         (clk),
        .resetn      (resetn),
        .in_valid    (ex_to_mem_valid),
        .in_data     (ex_to_mem),
        .out_allowin (wb_allowin),
        .in_allowin  (mem_allowin),
        .out_valid   (mem_to_wb_valid),
        .out_data    (mem_data)
    );

    //////////////////////////////
    // Result select
    //////////////////////////////

    // SRAM holds rdata while en is low, which covers a stalled load
    assign final_result = mem_data.res_from_mem ? data_sram_rdata : mem_data.alu_result;

    always_comb begin
        mem_to_wb.rf_we        = mem_data.rf_we;
        mem_to_wb.rf_waddr     = mem_data.rf_waddr;
        mem_to_wb.pc           = mem_data.pc;
        mem_to_wb.final_result = final_result;
    end

    // Forwarding, loaded value is ready here so decode can bypass it
    always_comb begin
        mem_fwd.is_load  = mem_to_wb_valid & mem_data.res_from_mem;
        mem_fwd.rf_we    = mem_to_wb_valid & mem_data.rf_we;
        mem_fwd.rf_waddr = mem_data.rf_waddr & {`EX_REG_AW{mem_to_wb_valid}};
        mem_fwd.value    = final_result & {`EX_DATA_W{mem_to_wb_valid}};
    end

endmodule

//--- design/ex_stage.sv
`include "ex_defines.svh"

module ex_stage (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  id_to_ex_valid,
    input  ex_pkg::id_to_ex_t     id_to_ex,
    output logic                  id_allowin,
    input  logic                  mem_allowin,
    output logic                  ex_to_mem_valid,
    output ex_pkg::ex_to_mem_t    ex_to_mem,
    output ex_pkg::fwd_t          ex_fwd,
    output logic                  data_sram_en,
    output logic [3:0]            data_sram_we,
    output logic [`EX_DATA_W-1:0] data_sram_addr,
    output logic [`EX_DATA_W-1:0] data_sram_wdata
);

    ex_pkg::id_to_ex_t     ex_data;
    logic [`EX_DATA_W-1:0] alu_result;
    logic                  ex_go;

    pipe_stage_reg #(.payload_t(ex_pkg::id_to_ex_t)) u_ex_reg (
        .clk         (clk),
        .resetn      (resetn),
        .in_valid    (id_to_ex_valid),
        .in_data     (id_to_ex),
        .out_allowin (mem_allowin),
        .in_allowin  (id_allowin),
        .out_valid   (ex_to_mem_valid),
        .out_data    (ex_data)
    );

    alu u_alu (
        .alu_op     (ex_data.alu_op),
        .alu_src1   (ex_data.alu_src1),
        .alu_src2   (ex_data.alu_src2),
        .alu_result (alu_result)
    );

    //////////////////////////////
    // Data SRAM strobes
    //////////////////////////////

    // Only on the cycle the instruction moves to mem, so a stalled store writes once
    assign ex_go           = ex_to_mem_valid & mem_allowin;
    assign data_sram_en    = ex_go & (ex_data.res_from_mem | ex_data.mem_we);
    assign data_sram_we    = {4{ex_go & ex_data.mem_we}};
    assign data_sram_addr  = alu_result;
    assign data_sram_wdata = ex_data.rkd_value;

    // Payload for mem
    always_comb begin
        ex_to_mem.rf_we        = ex_data.rf_we;
        ex_to_mem.rf_waddr     = ex_data.rf_waddr;
        ex_to_mem.pc           = ex_data.pc;
        ex_to_mem.alu_result   = alu_result;
        ex_to_mem.rkd_value    = ex_data.rkd_value;
        ex_to_mem.res_from_mem = ex_data.res_from_mem;
        ex_to_mem.mem_we       = ex_data.mem_we;
    end

    // Forwarding, all zero when the stage is empty
    always_comb begin
        ex_fwd.is_load  = ex_to_mem_valid & ex_data.res_from_mem;
        ex_fwd.rf_we    = ex_to_mem_valid & ex_data.rf_we;
        ex_fwd.rf_waddr = ex_data.rf_waddr & {`EX_REG_AW{ex_to_mem_valid}};
        ex_fwd.value    = alu_result & {`EX_DATA_W{ex_to_mem_valid}};
    end

endmodule

//--- design/alu.sv
`include "ex_defines.svh"

module alu (
    input  logic [`EX_ALU_OPS-1:0] alu_op,
    input  logic [`EX_DATA_W-1:0]  alu_src1,
    input  logic [`EX_DATA_W-1:0]  alu_src2,
    output logic [`EX_DATA_W-1:0]  alu_result
);

    localparam int W = `EX_DATA_W;

    logic         do_sub;
    logic [W-1:0] adder_b;
    logic [W-1:0] adder_sum;
    logic         adder_cout;
    logic [4:0]   shamt;

    logic [W-1:0] add_sub_res;
    logic [W-1:0] slt_res;
    logic [W-1:0] sltu_res;
    logic [W-1:0] and_res;
    logic [W-1:0] nor_res;
    logic [W-1:0] or_res;
    logic [W-1:0] xor_res;
    logic [W-1:0] sll_res;
    logic [W-1:0] srl_res;
    logic [W-1:0] sra_res;
    logic [W-1:0] lui_res;

    //////////////////////////////
    // Shared adder
    //////////////////////////////

    // Compares need src1 - src2 as well
    assign do_sub = alu_op[ex_pkg::op_sub] | alu_op[ex_pkg::op_slt] | alu_op[ex_pkg::op_sltu];
    assign adder_b = do_sub ? ~alu_src2 : alu_src2;
    assign {adder_cout, adder_sum} = {1'b0, alu_src1} + {1'b0, adder_b} + {{W{1'b0}}, do_sub};

    assign add_sub_res = adder_sum;

    // Signed less-than from operand signs and difference sign
    assign slt_res = {{(W-1){1'b0}},
                      (alu_src1[W-1] & ~alu_src2[W-1])
                      | (~(alu_src1[W-1] ^ alu_src2[W-1]) & adder_sum[W-1])};

    // No carry out of a - b means a borrow, so a < b unsigned
    assign sltu_res = {{(W-1){1'b0}}, ~adder_cout};

    //////////////////////////////
    // Logic and shifts
    //////////////////////////////

    assign and_res = alu_src1 & alu_src2;
    assign nor_res = ~(alu_src1 | alu_src2);
    assign or_res  = alu_src1 | alu_src2;
    assign xor_res = alu_src1 ^ alu_src2;

    assign shamt   = alu_src2[4:0];
    assign sll_res = alu_src1 << shamt;
    assign srl_res = alu_src1 >> shamt;
    assign sra_res = $signed(alu_src1) >>> shamt;

    // Immediate already placed by decode
    assign lui_res = alu_src2;

    // One-hot AND-OR select, zero when no op bit is set
    assign alu_result = ({W{alu_op[ex_pkg::op_add] | alu_op[ex_pkg::op_sub]}} & add_sub_res)
                      | ({W{alu_op[ex_pkg::op_slt]}}  & slt_res)
                      | ({W{alu_op[ex_pkg::op_sltu]}} & sltu_res)
                      | ({W{alu_op[ex_pkg::op_and]}}  & and_res)
                      | ({W{alu_op[ex_pkg::op_nor]}}  & nor_res)
                      | ({W{alu_op[ex_pkg::op_or]}}   & or_res)
                      | ({W{alu_op[ex_pkg::op_xor]}}  & xor_res)
                      | ({W{alu_op[ex_pkg::op_sll]}}  & sll_res)
                      | ({W{alu_op[ex_pkg::op_srl]}}  & srl_res)
                      | ({W{alu_op[ex_pkg::op_sra]}}  & sra_res)
                      | ({W{alu_op[ex_pkg::op_lui]}}  & lui_res);

endmodule

//--- design/pipe_stage_reg.sv
module pipe_stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     resetn,
    input  logic     in_valid,
    input  payload_t in_data,
    input  logic     out_allowin,
    output logic     in_allowin,
    output logic     out_valid,
    output payload_t out_data
);

    logic     valid_q;
    payload_t data_q;

    // Ready-go is always true, so a full stage drains whenever downstream accepts
    assign in_allowin = ~valid_q | out_allowin;
    assign out_valid  = valid_q;
    assign out_data   = data_q;

    // Occupancy, cleared when draining with nothing new arriving
    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_q <= 1'b0;
        end else if (in_allowin) begin
            valid_q <= in_valid;
        end
    end

    // Payload only moves on an actual transfer
    always_ff @(posedge clk) begin
        if (in_valid && in_allowin) begin
            data_q <= in_data;
        end
    end

endmodule

//--- design/ex_pkg.sv
`include "ex_defines.svh"

package ex_pkg;

    // Bit position of each operation in the one-hot alu_op vector
    typedef enum logic [3:0] {
        op_add  = 4'd0,
        op_sub  = 4'd1,
        op_slt  = 4'd2,
        op_sltu = 4'd3,
        op_and  = 4'd4,
        op_nor  = 4'd5,
        op_or   = 4'd6,
        op_xor  = 4'd7,
        op_sll  = 4'd8,
        op_srl  = 4'd9,
        op_sra  = 4'd10,
        op_lui  = 4'd11
    } alu_op_idx_e;

    //////////////////////////////
    // Stage payloads
    //////////////////////////////

    // Decoded instruction from decode, 148 bits
    typedef struct packed {
        logic [`EX_ALU_OPS-1:0] alu_op;
        logic [`EX_DATA_W-1:0]  alu_src1;
        logic [`EX_DATA_W-1:0]  alu_src2;
        logic                   rf_we;
        logic [`EX_REG_AW-1:0]  rf_waddr;
        logic [`EX_DATA_W-1:0]  pc;
        logic                   mem_we;
        logic [`EX_DATA_W-1:0]  rkd_value;
        logic                   res_from_mem;
    } id_to_ex_t;

    // Executed instruction, 104 bits
    typedef struct packed {
        logic                   rf_we;
        logic [`EX_REG_AW-1:0]  rf_waddr;
        logic [`EX_DATA_W-1:0]  pc;
        logic [`EX_DATA_W-1:0]  alu_result;
        logic [`EX_DATA_W-1:0]  rkd_value;
        logic                   res_from_mem;
        logic                   mem_we;
    } ex_to_mem_t;

    // Write-back request, 70 bits
    typedef struct packed {
        logic                   rf_we;
        logic [`EX_REG_AW-1:0]  rf_waddr;
        logic [`EX_DATA_W-1:0]  pc;
        logic [`EX_DATA_W-1:0]  final_result;
    } mem_to_wb_t;

    // Bypass and load-use info toward decode, 39 bits
    typedef struct packed {
        logic                   is_load;
        logic                   rf_we;
        logic [`EX_REG_AW-1:0]  rf_waddr;
        logic [`EX_DATA_W-1:0]  value;
    } fwd_t;

endpackage

//--- design/ex_defines.svh
`ifndef EX_DEFINES_SVH
`define EX_DEFINES_SVH

// Datapath and SRAM address width
`define EX_DATA_W 32

// Register file address width
`define EX_REG_AW 5

// One-hot ALU operation vector width
`define EX_ALU_OPS 12

`endif
